//--- common/mm_pkg.sv
// Sizes and vector types shared by the matrix multiply design.
// Modules refer to these by scoped names, e.g. mm_pkg::vec_t.

package mm_pkg;

    // square matrices only
    localparam int N        = 3;
    localparam int DATA_W   = 4;
    localparam int RESULT_W = 8;
    localparam int IDX_W    = 2;

    // one operand element
    typedef logic [DATA_W-1:0] elem_t;

    // packed row of A or column of B, element 0 in the low bits
    typedef logic [N*DATA_W-1:0] vec_t;

    // one result element, dot product modulo 256
    typedef logic [RESULT_W-1:0] sum_t;

    // packed result row, column 0 in the low bits
    typedef logic [N*RESULT_W-1:0] res_row_t;

    // row or column index
    typedef logic [IDX_W-1:0] idx_t;

endpackage

//--- common/mm_seq_if.sv
// Compute and read-out sequence from the controller to the datapath.
// The controller drives ctrl, the pipeline and result store take pipe.

interface mm_seq_if;

    logic          issue;    // pair fetched this cycle
    mm_pkg::idx_t  row_sel;
    mm_pkg::idx_t  col_sel;
    logic          rd_issue; // result row fetched this cycle
    mm_pkg::idx_t  rd_row;

    modport ctrl (
        output issue, row_sel, col_sel, rd_issue, rd_row
    );

    modport pipe (
        input issue, row_sel, col_sel, rd_issue, rd_row
    );

endinterface

//--- control/mm_control.sv
// Sequencer for computation and read-out.
// start walks the nine row/column pairs row-major, waits for the pipeline
// to drain and pulses done; read steps through the result rows and pulses
// read_done with the last output beat.

module mm_control (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  logic       read,
    mm_seq_if.ctrl     seq,
    output logic       done,
    output logic       read_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_drain,
        st_readout
    } mm_state_t;

    localparam mm_pkg::idx_t LAST_IDX = mm_pkg::idx_t'(mm_pkg::N - 1);

    mm_state_t state;
    logic      drain_cnt; // two drain cycles

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= st_idle;
            drain_cnt    <= 1'b0;
            seq.issue    <= 1'b0;
            seq.row_sel  <= '0;
            seq.col_sel  <= '0;
            seq.rd_issue <= 1'b0;
            seq.rd_row   <= '0;
            done         <= 1'b0;
            read_done    <= 1'b0;
        end else begin
            done      <= 1'b0;
            read_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state       <= st_compute;
                        seq.issue   <= 1'b1;
                        seq.row_sel <= '0;
                        seq.col_sel <= '0;
                    end else if (read) begin
                        state        <= st_readout;
                        seq.rd_issue <= 1'b1;
                        seq.rd_row   <= '0;
                    end
                end
                st_compute: begin
                    if (seq.col_sel == LAST_IDX) begin
                        seq.col_sel <= '0;
                        if (seq.row_sel == LAST_IDX) begin
                            seq.issue <= 1'b0;
                            drain_cnt <= 1'b0;
                            state     <= st_drain;
                        end else begin
                            seq.row_sel <= seq.row_sel + 1'b1;
                        end
                    end else begin
                        seq.col_sel <= seq.col_sel + 1'b1;
                    end
                end
                st_drain: begin
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin // last sum written this cycle
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                end
                st_readout: begin
                    if (seq.rd_row == LAST_IDX) begin
                        seq.rd_issue <= 1'b0;
                        read_done    <= 1'b1; // lines up with third beat
                        state        <= st_idle;
                    end else begin
                        seq.rd_row <= seq.rd_row + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- verilog/operand_memory.sv
// Storage for the three packed rows of A or columns of B.
// Synchronous write from the host port, read data valid one cycle
// after read_address.

module operand_memory (
    input  logic          clk,
    input  logic          write_enable,
    input  mm_pkg::idx_t  write_address,
    input  mm_pkg::vec_t  datain,
    input  mm_pkg::idx_t  read_address,
    output mm_pkg::vec_t  dataout
);

    mm_pkg::vec_t mem [mm_pkg::N];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_address] <= datain;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        dataout <= mem[read_address];
    end

endmodule

//--- compute/dot_product.sv
// Two-stage dot product of one row of A and one column of B.
// Stage one carries issue and the pair position alongside the memory read,
// stage two multiplies, adds modulo 256 and registers the sum with its tags.

module dot_product (
    input  logic          clk,
    input  logic          resetn,
    mm_seq_if.pipe        seq,
    input  mm_pkg::vec_t  a_vec,
    input  mm_pkg::vec_t  b_vec,
    output logic          sum_valid,
    output mm_pkg::sum_t  sum,
    output mm_pkg::idx_t  sum_row,
    output mm_pkg::idx_t  sum_col
);

    logic         s1_valid;
    mm_pkg::idx_t s1_row;
    mm_pkg::idx_t s1_col;
    mm_pkg::sum_t dot;

    // stage one, aligned with operand read data
    always_ff @(posedge clk) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= seq.issue;
        end
    end

    always_ff @(posedge clk) begin
        s1_row <= seq.row_sel;
        s1_col <= seq.col_sel;
    end

    // 4x4 products fit in 8 bits, the sum wraps
    always_comb begin
        mm_pkg::elem_t a_el;
        mm_pkg::elem_t b_el;
        dot = '0;
        for (int i = 0; i < mm_pkg::N; i++) begin
            a_el = a_vec[i*mm_pkg::DATA_W +: mm_pkg::DATA_W];
            b_el = b_vec[i*mm_pkg::DATA_W +: mm_pkg::DATA_W];
            dot  = dot + mm_pkg::sum_t'(a_el * b_el);
        end
    end

    // stage two
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        sum     <= dot;
        sum_row <= s1_row;
        sum_col <= s1_col;
    end

endmodule

//--- compute/result_memory.sv
// Result store. Sums of one row are gathered by column and the complete
// row is written when its column-2 sum arrives. Read-out replays a stored
// row one cycle after rd_issue, with its address and a valid flag.

module result_memory (
    input  logic              clk,
    input  logic              resetn,
    mm_seq_if.pipe            seq,
    input  logic              sum_valid,
    input  mm_pkg::sum_t      sum,
    input  mm_pkg::idx_t      sum_row,
    input  mm_pkg::idx_t      sum_col,
    output mm_pkg::res_row_t  dataout,
    output mm_pkg::idx_t      address_out,
    output logic              dataout_valid
);

    localparam mm_pkg::idx_t LAST_COL = mm_pkg::idx_t'(mm_pkg::N - 1);
    localparam int           RW       = mm_pkg::RESULT_W;

    mm_pkg::res_row_t gather;
    mm_pkg::res_row_t row_word;
    mm_pkg::res_row_t mem [mm_pkg::N];

    // gather register with the incoming sum merged in
    always_comb begin
        row_word = gather;
        row_word[sum_col*RW +: RW] = sum;
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            gather <= row_word;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid && sum_col == LAST_COL) begin
            mem[sum_row] <= row_word; // row complete
        end
    end

    // read-out port
    always_ff @(posedge clk) begin
        if (seq.rd_issue) begin
            dataout     <= mem[seq.rd_row];
            address_out <= seq.rd_row;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dataout_valid <= 1'b0;
        end else begin
            dataout_valid <= seq.rd_issue;
        end
    end

endmodule

//--- verilog/matrix_multiply.sv
// Top level of the 3x3 matrix multiplier.
// The host loads rows of A and columns of B through mem_datain, pulses start
// and waits for done, then pulses read to get the three result rows.

module matrix_multiply (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  logic              read,
    input  logic              row_write_enable,
    input  logic              col_write_enable,
    input  mm_pkg::vec_t      mem_datain,
    input  mm_pkg::idx_t      mem_address,
    output mm_pkg::res_row_t  mem_dataout,
    output mm_pkg::idx_t      mem_address_out,
    output logic              mem_dataout_valid,
    output logic              done,
    output logic              read_done
);

    mm_seq_if seq ();

    mm_pkg::vec_t a_vec;
    mm_pkg::vec_t b_vec;
    logic         sum_valid;
    mm_pkg::sum_t sum;
    mm_pkg::idx_t sum_row;
    mm_pkg::idx_t sum_col;

    mm_control u_control (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .read      (read),
        .seq       (seq.ctrl),
        .done      (done),
        .read_done (read_done)
    );

    operand_memory a_rows (
        .clk           (clk),
        .write_enable  (row_write_enable),
        .write_address (mem_address),
        .datain        (mem_datain),
        .read_address  (seq.row_sel),
        .dataout       (a_vec)
    );

    operand_memory b_cols (
        .clk           (clk),
        .write_enable  (col_write_enable),
        .write_address (mem_address),
        .datain        (mem_datain),
        .read_address  (seq.col_sel),
        .dataout       (b_vec)
    );

    dot_product u_dot_product (
        .clk       (clk),
        .resetn    (resetn),
        .seq       (seq.pipe),
        .a_vec     (a_vec),
        .b_vec     (b_vec),
        .sum_valid (sum_valid),
        .sum       (sum),
        .sum_row   (sum_row),
        .sum_col   (sum_col)
    );

    result_memory u_result_memory (
        .clk           (clk),
        .resetn        (resetn),
        .seq           (seq.pipe),
        .sum_valid     (sum_valid),
        .sum           (sum),
        .sum_row       (sum_row),
        .sum_col       (sum_col),
        .dataout       (mem_dataout),
        .address_out   (mem_address_out),
        .dataout_valid (mem_dataout_valid)
    );

endmodule

//--- tests/matrix_multiply_chk.sv
// Protocol and timing assertions for matrix_multiply, bound into the DUT.
// Tracks when the controller is busy so that ignored pulses can be told
// apart from accepted ones. fail_count is read by the testbench.

module matrix_multiply_chk (
    input  logic          clk,
    input  logic          resetn,
    input  logic          start,
    input  logic          read,
    input  logic          done,
    input  logic          read_done,
    input  logic          valid,
    input  mm_pkg::idx_t  addr
);

    logic comp_busy;
    logic rd_busy;
    logic idle;
    logic start_acc;
    logic read_acc;
    int   fail_count = 0;

    // done and read_done are seen in the first idle cycle
    assign idle      = (!comp_busy && !rd_busy) || done || read_done;
    assign start_acc = start && idle;
    assign read_acc  = read && !start && idle; // start wins in idle

    always_ff @(posedge clk) begin
        if (!resetn) begin
            comp_busy <= 1'b0;
            rd_busy   <= 1'b0;
        end else begin
            if (start_acc) begin
                comp_busy <= 1'b1;
            end else if (done) begin
                comp_busy <= 1'b0;
            end
            if (read_acc) begin
                rd_busy <= 1'b1;
            end else if (read_done) begin
                rd_busy <= 1'b0;
            end
        end
    end

    a_done_timing: assert property (@(posedge clk) disable iff (!resetn)
        start_acc |=> !done [*11] ##1 done ##1 !done)
        else begin
            $error("done did not follow start after exactly 12 cycles");
            fail_count++;
        end

    a_done_owned: assert property (@(posedge clk) disable iff (!resetn)
        done |-> comp_busy)
        else begin
            $error("done pulsed with no computation running");
            fail_count++;
        end

    a_read_valid: assert property (@(posedge clk) disable iff (!resetn)
        read_acc |=> !valid ##1 valid [*3] ##1 !valid)
        else begin
            $error("mem_dataout_valid not high for three cycles from read + 2");
            fail_count++;
        end

    a_read_addr: assert property (@(posedge clk) disable iff (!resetn)
        read_acc |-> ##2 addr == 2'd0 ##1 addr == 2'd1 ##1 addr == 2'd2)
        else begin
            $error("mem_address_out did not count 0, 1, 2");
            fail_count++;
        end

    a_read_done: assert property (@(posedge clk) disable iff (!resetn)
        read_done |-> valid && addr == 2'd2 && rd_busy)
        else begin
            $error("read_done not aligned with the third output beat");
            fail_count++;
        end

    a_valid_owned: assert property (@(posedge clk) disable iff (!resetn)
        valid |-> rd_busy)
        else begin
            $error("mem_dataout_valid high with no read-out running");
            fail_count++;
        end

endmodule

bind matrix_multiply matrix_multiply_chk chk (
    .clk       (clk),
    .resetn    (resetn),
    .start     (start),
    .read      (read),
    .done      (done),
    .read_done (read_done),
    .valid     (mem_dataout_valid),
    .addr      (mem_address_out)
);

//--- tests/matrix_multiply_tb.sv
// Testbench for the 3x3 matrix multiplier. Loads operands, runs compute and
// read-out and compares each output row with a reference model.
// Protocol timing is checked by the bound matrix_multiply_chk.

module matrix_multiply_tb;

    localparam int N        = mm_pkg::N;
    localparam int LOAD_CYC = 2 * N;
    localparam int COMP_CYC = 14;
    localparam int READ_CYC = 6;
    localparam int PASS_CYC = LOAD_CYC + COMP_CYC + READ_CYC;
    // reset, quiet window, five passes, extra reads, done window, doubled
    localparam int WATCHDOG_CYC = 2 * (4 + 8 + 5 * PASS_CYC + 3 * READ_CYC + 16);

    logic              clk;
    logic              resetn;
    logic              start;
    logic              read;
    logic              row_write_enable;
    logic              col_write_enable;
    mm_pkg::vec_t      mem_datain;
    mm_pkg::idx_t      mem_address;
    mm_pkg::res_row_t  mem_dataout;
    mm_pkg::idx_t      mem_address_out;
    logic              mem_dataout_valid;
    logic              done;
    logic              read_done;

    mm_pkg::elem_t    a_m [N][N];
    mm_pkg::elem_t    b_m [N][N];   // b_m[k][c] is element k of column c
    mm_pkg::res_row_t exp_row [N];

    integer seed;
    int     errors;
    int     tests_run;
    int     tests_passed;
    int     mark;
    int     done_count;

    matrix_multiply dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic check_low(input string name, input logic v);
        if (v !== 1'b0) begin
            $display("[ERROR] t=%0t %s: expected 0, got %b", $time, name, v);
            errors++;
        end
    endtask

    task automatic random_operands();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                a_m[r][c] = mm_pkg::elem_t'($random(seed));
                b_m[r][c] = mm_pkg::elem_t'($random(seed));
            end
        end
    endtask

    // rows of A then columns of B, one vector per cycle
    task automatic load_matrices();
        for (int i = 0; i < N; i++) begin
            mem_address      = mm_pkg::idx_t'(i);
            mem_datain       = {a_m[i][2], a_m[i][1], a_m[i][0]};
            row_write_enable = 1'b1;
            step();
            row_write_enable = 1'b0;
            mem_datain       = {b_m[2][i], b_m[1][i], b_m[0][i]};
            col_write_enable = 1'b1;
            step();
            col_write_enable = 1'b0;
        end
    endtask

    function automatic mm_pkg::sum_t ref_entry(input int r, input int c);
        int acc;
        acc = 0;
        for (int k = 0; k < N; k++) begin
            acc += a_m[r][k] * b_m[k][c];
        end
        return mm_pkg::sum_t'(acc % 256); // wraps at 8 bits
    endfunction

    task automatic model_rows();
        for (int r = 0; r < N; r++) begin
            exp_row[r] = {ref_entry(r, 2), ref_entry(r, 1), ref_entry(r, 0)};
        end
    endtask

    task automatic run_compute();
        start = 1'b1;
        step();
        start = 1'b0;
        while (!done) step();
    endtask

    task automatic read_and_check();
        int beats;
        bit last;
        beats = 0;
        last  = 1'b0;
        read  = 1'b1;
        step();
        read = 1'b0;
        while (!last) begin
            if (mem_dataout_valid) begin
                beats++;
                if (mem_dataout !== exp_row[mem_address_out]) begin
                    $display("[ERROR] t=%0t mem_dataout row %0d: expected %h, got %h",
                             $time, mem_address_out, exp_row[mem_address_out], mem_dataout);
                    errors++;
                end
            end
            if (read_done) last = 1'b1;
            else step();
        end
        if (beats != N) begin
            $display("read-out returned %0d rows instead of three", beats);
            errors++;
        end
    endtask

    task automatic begin_test();
        mark = errors + dut.chk.fail_count;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        int n;
        repeat (2) step(); // bound assertions on the last beats finish here
        n = errors + dut.chk.fail_count - mark;
        if (n == 0) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d errors", name, n);
        end
    endtask

    initial begin
        seed             = 32'h6282;
        errors           = 0;
        tests_run        = 0;
        tests_passed     = 0;
        mark             = 0;
        done_count       = 0;
        resetn           = 1'b0;
        start            = 1'b0;
        read             = 1'b0;
        row_write_enable = 1'b0;
        col_write_enable = 1'b0;
        mem_datain       = '0;
        mem_address      = '0;
        repeat (4) step();
        resetn = 1'b1;

        begin_test();
        repeat (8) begin
            step();
            check_low("done", done);
            check_low("read_done", read_done);
            check_low("mem_dataout_valid", mem_dataout_valid);
        end
        end_test("reset");

        begin_test();
        random_operands();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                a_m[r][c] = (r == c) ? 4'd1 : 4'd0;
            end
            exp_row[r] = {mm_pkg::sum_t'(b_m[r][2]),
                          mm_pkg::sum_t'(b_m[r][1]),
                          mm_pkg::sum_t'(b_m[r][0])}; // element r of each column
        end
        load_matrices();
        run_compute();
        read_and_check();
        end_test("identity");

        begin_test();
        random_operands();
        load_matrices();
        model_rows();
        run_compute();
        read_and_check();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                a_m[r][c] = 4'hf;
                b_m[r][c] = 4'hf;
            end
        end
        load_matrices();
        model_rows();
        run_compute();
        read_and_check();
        end_test("overflow");

        begin_test();
        read_and_check();
        read_and_check();
        end_test("read timing");

        begin_test();
        random_operands();
        load_matrices();
        model_rows();
        start = 1'b1;
        step();
        start = 1'b0;
        repeat (3) step();
        start = 1'b1; // lands mid compute
        step();
        start = 1'b0;
        while (!done) step();
        done_count = 1;
        repeat (16) begin
            step();
            if (done) done_count++;
        end
        if (done_count != 1) begin
            $display("start during compute gave %0d done pulses instead of one", done_count);
            errors++;
        end
        read_and_check();
        random_operands();
        load_matrices();
        model_rows();
        run_compute();
        read_and_check();
        end_test("ignored start");

        $display("%0d of %0d tests passed, %0d data errors, %0d assertion failures",
                 tests_passed, tests_run, errors, dut.chk.fail_count);
        if (errors == 0 && dut.chk.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("run timed out after %0d cycles waiting for the DUT", WATCHDOG_CYC);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- matrix_multiply.f
common/mm_pkg.sv
common/mm_seq_if.sv
control/mm_control.sv
verilog/operand_memory.sv
compute/dot_product.sv
compute/result_memory.sv
verilog/matrix_multiply.sv
tests/matrix_multiply_chk.sv
tests/matrix_multiply_tb.sv

//--- Bender.yml
package:
  name: matrix_multiply

sources:
  - files:
      - common/mm_pkg.sv
      - common/mm_seq_if.sv
      - control/mm_control.sv
      - verilog/operand_memory.sv
      - compute/dot_product.sv
      - compute/result_memory.sv
      - verilog/matrix_multiply.sv
  - target: test
    files:
      - tests/matrix_multiply_chk.sv
      - tests/matrix_multiply_tb.sv
